// File: Bender.yml
package:
  name: board_specific_top

export_include_dirs:
  - include

sources:
  - src/board_pkg.sv
  - src/slow_clk_gen.sv
  - src/seg7_scanner.sv
  - src/static_seg7_latch.sv
  - src/inmp441_mic_i2s_receiver.sv
  - src/lab_top.sv
  - src/board_specific_top.sv
  - target: test
    files:
      - test/tb_board_specific_top.sv

// File: board_specific_top.f
+incdir+include
src/board_pkg.sv
src/slow_clk_gen.sv
src/seg7_scanner.sv
src/static_seg7_latch.sv
src/inmp441_mic_i2s_receiver.sv
src/lab_top.sv
src/board_specific_top.sv
test/tb_board_specific_top.sv

// File: include/board_params.svh
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// ---------------------------------------------------------------------------
// Board resources
// ---------------------------------------------------------------------------

`define BOARD_W_KEY        4     // Push keys
`define BOARD_W_SW         10    // Slide switches, top one reserved
`define BOARD_W_DIGIT      4     // Static seven-segment digits
`define BOARD_W_LEDR       10    // Red LED row, top BOARD_W_DIGIT used as dp
`define BOARD_W_LEDG       8     // Green LED row

// ---------------------------------------------------------------------------
// INMP441 I2S frame timing
// ---------------------------------------------------------------------------

`define MIC_SCK_DIV        4     // clk cycles per half sck period
`define MIC_BITS_PER_SLOT  32    // sck periods per ws half-frame
`define MIC_SAMPLE_BITS    24    // Sample width delivered by the microphone

`endif

// File: src/board_pkg.sv
`include "board_params.svh"

package board_pkg;

    // -----------------------------------------------------------------------
    // Segment word
    // -----------------------------------------------------------------------

    typedef struct packed {
        logic a;                                  // Top bit of the abcdefgh bus
        logic b;
        logic c;
        logic d;
        logic e;
        logic f;
        logic g;
        logic dp;                                 // Bottom bit, aka h
    } seg_fields_t;

    typedef union packed {
        logic [7:0]  raw;                         // Scanner view
        seg_fields_t fields;                      // Latch view
    } seg_word_u;

    // One-hot digit strobe, bit 0 is the rightmost digit
    typedef logic [`BOARD_W_DIGIT-1:0] digit_sel_t;

    // Lab LEDs, the upper red LEDs stay free for dp
    typedef struct packed {
        logic [`BOARD_W_LEDR-`BOARD_W_DIGIT-1:0] ledr_low;
        logic [`BOARD_W_LEDG-1:0]                ledg;
    } led_bus_t;

    typedef logic signed [`MIC_SAMPLE_BITS-1:0] mic_sample_t;   // Two's complement PCM

endpackage

// File: src/board_specific_top.sv
`timescale 1ns/10ps
`include "board_params.svh"

module board_specific_top
    import board_pkg::*;
#(
    parameter tick_div = 25_000_000,                // Slow tick period in clk cycles
    parameter scan_div = 50_000                     // Digit scan period in clk cycles
)
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`BOARD_W_KEY-1:0]  key,           // Active low
    input  logic [`BOARD_W_SW-1:0]   sw,
    input  logic                     mic_sd,
    output logic [`BOARD_W_LEDR-1:0] ledr,          // Top BOARD_W_DIGIT act as dp
    output logic [`BOARD_W_LEDG-1:0] ledg,
    output logic [6:0]               hex0,
    output logic [6:0]               hex1,
    output logic [6:0]               hex2,
    output logic [6:0]               hex3,
    output logic                     mic_sck,
    output logic                     mic_ws,
    output logic                     mic_lr
);

    localparam int w_lab_sw = `BOARD_W_SW - 1;      // Top switch reserved

    logic [`BOARD_W_KEY-1:0] lab_key;
    logic [w_lab_sw-1:0]     lab_sw;
    logic                    slow_tick;
    mic_sample_t             mic_value;
    led_bus_t                leds;
    seg_word_u               seg;
    digit_sel_t              digit;
    digit_sel_t              dp;

    assign lab_key = ~key;
    assign lab_sw  = sw[w_lab_sw-1:0];
    assign mic_lr  = 1'b0;                          // Left channel

    //------------------------------------------------------------------------

    slow_clk_gen #(.tick_div (tick_div)) slow_clk_gen_inst
    (
        .clk       (clk),
        .rst       (rst),
        .slow_tick (slow_tick)
    );

    lab_top #(.scan_div (scan_div)) lab_top_inst
    (
        .clk       (clk),
        .rst       (rst),
        .slow_tick (slow_tick),
        .key       (lab_key),
        .sw        (lab_sw),
        .mic       (mic_value),
        .leds      (leds),
        .seg       (seg),
        .digit     (digit)
    );

    inmp441_mic_i2s_receiver mic_inst
    (
        .clk   (clk),
        .rst   (rst),
        .sd    (mic_sd),
        .sck   (mic_sck),
        .ws    (mic_ws),
        .value (mic_value)
    );

    static_seg7_latch static_seg7_latch_inst
    (
        .clk   (clk),
        .rst   (rst),
        .seg   (seg),
        .digit (digit),
        .hex0  (hex0),
        .hex1  (hex1),
        .hex2  (hex2),
        .hex3  (hex3),
        .dp    (dp)
    );

    //------------------------------------------------------------------------

    assign ledr[`BOARD_W_LEDR-1 -: `BOARD_W_DIGIT]    = dp;   // No dp pins on the HEX
    assign ledr[`BOARD_W_LEDR-`BOARD_W_DIGIT-1:0]     = leds.ledr_low;
    assign ledg                                       = leds.ledg;

endmodule

// File: src/inmp441_mic_i2s_receiver.sv
`timescale 1ns/10ps
`include "board_params.svh"

module inmp441_mic_i2s_receiver
    import board_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        sd,                         // Serial data from the mic
    output logic        sck,                        // Bit clock
    output logic        ws,                         // Low selects left slot
    output mic_sample_t value                       // Last left sample
);

    localparam int div_w = (`MIC_SCK_DIV > 1) ? $clog2(`MIC_SCK_DIV) : 1;
    localparam int bit_w = $clog2(2 * `MIC_BITS_PER_SLOT);     // Periods per frame

    logic [div_w-1:0]            div_cnt;           // clk cycles within half sck
    logic [bit_w-1:0]            bit_cnt;           // sck period within frame
    logic                        sck_edge;
    logic                        sck_rise;
    logic                        sck_fall;
    logic                        take_bit;
    logic                        last_bit;
    logic                        load_q;
    logic [`MIC_SAMPLE_BITS-1:0] shreg;             // Incoming bits, MSB first

    assign sck_edge = (div_cnt == div_w'(`MIC_SCK_DIV - 1));
    assign sck_rise = sck_edge & ~sck;
    assign sck_fall = sck_edge & sck;
    assign ws       = bit_cnt[bit_w-1];             // Moves only on falling sck

    // I2S puts the MSB one period after ws falls
    assign take_bit = sck_rise & ~ws
                    & (bit_cnt[bit_w-2:0] >= 1)
                    & (bit_cnt[bit_w-2:0] <= `MIC_SAMPLE_BITS);
    assign last_bit = take_bit & (bit_cnt[bit_w-2:0] == `MIC_SAMPLE_BITS);

    //------------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
            load_q  <= 1'b0;
            value   <= '0;
        end
        else
        begin
            div_cnt <= sck_edge ? '0 : div_cnt + 1'b1;
            if (sck_edge)
                sck <= ~sck;
            if (sck_fall)
                bit_cnt <= bit_cnt + 1'b1;          // Wraps every frame
            load_q <= last_bit;
            if (load_q)
                value <= mic_sample_t'(shreg);      // Hold until next frame
        end

    always_ff @(posedge clk)
        if (take_bit)
            shreg <= {shreg[`MIC_SAMPLE_BITS-2:0], sd};

    //------------------------------------------------------------------------

    a_ws_sck_low : assert property (@(posedge clk) disable iff (rst)
        $changed(ws) |-> !sck)
        else $error("ws changed while sck high");

endmodule

// File: src/lab_top.sv
`timescale 1ns/10ps
`include "board_params.svh"

module lab_top
    import board_pkg::*;
#(
    parameter scan_div = 50_000
)
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    slow_tick,
    input  logic [`BOARD_W_KEY-1:0] key,            // Active high
    input  logic [`BOARD_W_SW-2:0]  sw,
    input  mic_sample_t             mic,
    output led_bus_t                leds,
    output seg_word_u               seg,
    output digit_sel_t              digit
);

    logic [1:0]                  key_s1;            // Synchronizer, keys 1 and 0
    logic [1:0]                  key_s2;
    logic [1:0]                  key_d;             // Previous synced level
    logic [1:0]                  key_rise;
    logic [`BOARD_W_DIGIT*4-1:0] count;             // Key press counter
    logic [`BOARD_W_DIGIT*4-1:0] show;              // Displayed word
    logic                        blink;

    assign key_rise = key_s2 & ~key_d;

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            key_s1 <= '0;
            key_s2 <= '0;
            key_d  <= '0;
            count  <= '0;
            blink  <= 1'b0;
        end
        else
        begin
            key_s1 <= key[1:0];
            key_s2 <= key_s1;
            key_d  <= key_s2;
            if (key_rise[1])
                count <= '0;                        // Key 1 clears
            else if (key_rise[0])
                count <= count + 1'b1;
            if (slow_tick)
                blink <= ~blink;
        end

    assign show = sw[0] ? mic[`MIC_SAMPLE_BITS-1 -: `BOARD_W_DIGIT*4] : count;

    assign leds.ledr_low = sw[5:0];
    assign leds.ledg     = {blink, count[6:0]};

    seg7_scanner #(.scan_div (scan_div)) seg7_scanner_inst
    (
        .clk     (clk),
        .rst     (rst),
        .nibbles (show),
        .dots    (sw[4:1]),                         // Decimal point mask
        .seg     (seg),
        .digit   (digit)
    );

endmodule

// File: src/seg7_scanner.sv
`timescale 1ns/10ps
`include "board_params.svh"

module seg7_scanner
    import board_pkg::*;
#(
    parameter scan_div = 50_000                     // clk cycles per digit
)
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`BOARD_W_DIGIT*4-1:0] nibbles,    // Digit 0 in the low nibble
    input  digit_sel_t                  dots,       // Decimal point mask
    output seg_word_u                   seg,
    output digit_sel_t                  digit
);

    localparam int cnt_w = (scan_div > 1) ? $clog2(scan_div) : 1;

    logic [cnt_w-1:0] pre_cnt;                      // Scan prescaler
    logic [3:0]       nib;                          // Nibble of the active digit
    logic             dot;

    // Hex font in abcdefg order
    function automatic logic [6:0] hex_font(input logic [3:0] value);
        logic [6:0] pat;
        case (value)
            4'h0:    pat = 7'b1111110;
            4'h1:    pat = 7'b0110000;
            4'h2:    pat = 7'b1101101;
            4'h3:    pat = 7'b1111001;
            4'h4:    pat = 7'b0110011;
            4'h5:    pat = 7'b1011011;
            4'h6:    pat = 7'b1011111;
            4'h7:    pat = 7'b1110000;
            4'h8:    pat = 7'b1111111;
            4'h9:    pat = 7'b1111011;
            4'ha:    pat = 7'b1110111;
            4'hb:    pat = 7'b0011111;              // Lower case b
            4'hc:    pat = 7'b1001110;
            4'hd:    pat = 7'b0111101;              // Lower case d
            4'he:    pat = 7'b1001111;
            default: pat = 7'b1000111;              // F
        endcase
        return pat;
    endfunction

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            pre_cnt <= '0;
            digit   <= digit_sel_t'(1);             // Digit 0 first
        end
        else if (pre_cnt == cnt_w'(scan_div - 1))
        begin
            pre_cnt <= '0;
            digit   <= {digit[`BOARD_W_DIGIT-2:0], digit[`BOARD_W_DIGIT-1]};
        end
        else
            pre_cnt <= pre_cnt + 1'b1;

    always_comb
    begin
        nib = '0;
        for (int i = 0; i < `BOARD_W_DIGIT; i++)
            if (digit[i])
                nib = nibbles[i*4 +: 4];            // One-hot mux
    end

    assign dot     = |(dots & digit);
    assign seg.raw = {hex_font(nib), dot};          // h is the dot

    a_digit_onehot : assert property (@(posedge clk) disable iff (rst)
        $onehot(digit))
        else $error("digit strobe not one-hot");

endmodule

// File: src/slow_clk_gen.sv
`timescale 1ns/10ps

module slow_clk_gen
#(
    parameter tick_div = 25_000_000                 // clk cycles per tick
)
(
    input  logic clk,
    input  logic rst,
    output logic slow_tick                          // One cycle strobe
);

    localparam int cnt_w = (tick_div > 1) ? $clog2(tick_div) : 1;

    logic [cnt_w-1:0] cnt;                          // Down-counter

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            cnt       <= cnt_w'(tick_div - 1);
            slow_tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt       <= cnt_w'(tick_div - 1);      // Reload
            slow_tick <= 1'b1;
        end
        else
        begin
            cnt       <= cnt - 1'b1;
            slow_tick <= 1'b0;
        end

    // Strobe is a single cycle wide so that users can treat it as an enable
    a_tick_single : assert property (@(posedge clk) disable iff (rst)
        slow_tick |=> !slow_tick)
        else $error("slow_tick high for two cycles");

endmodule

// File: src/static_seg7_latch.sv
`timescale 1ns/10ps
`include "board_params.svh"

module static_seg7_latch
    import board_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  seg_word_u  seg,                         // Scanned segment bus
    input  digit_sel_t digit,
    output logic [6:0] hex0,                        // Active low, gfedcba
    output logic [6:0] hex1,
    output logic [6:0] hex2,
    output logic [6:0] hex3,
    output digit_sel_t dp                           // Active high
);

    logic [6:0] hex_q [`BOARD_W_DIGIT];             // Sticky per-digit patterns
    logic [6:0] hex_new;

    // Static digits want g in the top bit and a low level to light
    assign hex_new = ~{seg.fields.g, seg.fields.f, seg.fields.e, seg.fields.d,
                       seg.fields.c, seg.fields.b, seg.fields.a};

    //------------------------------------------------------------------------
    // Each digit holds its last pattern between strobes, keeping full brightness

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            hex_q <= '{default: '1};                // Blank
            dp    <= '0;
        end
        else
        begin
            for (int i = 0; i < `BOARD_W_DIGIT; i++)
                if (digit[i])
                begin
                    hex_q[i] <= hex_new;
                    dp[i]    <= seg.fields.dp;
                end
        end

    //------------------------------------------------------------------------

    assign hex0 = hex_q[0];
    assign hex1 = hex_q[1];
    assign hex2 = hex_q[2];
    assign hex3 = hex_q[3];

endmodule

// File: test/tb_board_specific_top.sv
`timescale 1ns/10ps
`include "board_params.svh"

module tb_board_specific_top
    import board_pkg::*;
;

    localparam int tick_div     = 8;
    localparam int scan_div     = 4;
    localparam int frame_cycles = 2 * `MIC_BITS_PER_SLOT * 2 * `MIC_SCK_DIV;   // 512
    localparam int max_tests    = 64;

    logic                     clk;
    logic                     rst;
    logic [`BOARD_W_KEY-1:0]  key;
    logic [`BOARD_W_SW-1:0]   sw;
    logic                     mic_sd;
    logic [`BOARD_W_LEDR-1:0] ledr;
    logic [`BOARD_W_LEDG-1:0] ledg;
    logic [6:0]               hex0;
    logic [6:0]               hex1;
    logic [6:0]               hex2;
    logic [6:0]               hex3;
    logic                     mic_sck;
    logic                     mic_ws;
    logic                     mic_lr;

    string                    t_name    [max_tests];   // Test table from the stim file
    logic [`BOARD_W_SW-1:0]   t_sw      [max_tests];
    int                       t_presses [max_tests];
    mic_sample_t              t_sample  [max_tests];
    digit_sel_t               t_dp      [max_tests];
    int                       n_tests;
    int                       n_errors;
    int                       cycle_count;
    int                       cycle_limit;
    mic_sample_t              mic_sample;            // Sample the mic model sends
    mic_sample_t              frame_smp;             // Sample latched for this frame
    logic                     sck_prev;
    logic                     ws_prev;
    logic                     ws_mon;
    logic                     sck_mon;
    int                       sck_run;               // clk cycles since the last sck edge
    int                       slot_per;              // sck period within ws slot

    board_specific_top #(.tick_div (tick_div), .scan_div (scan_div)) board_specific_top_inst
    (
        .clk (clk), .rst (rst), .key (key), .sw (sw), .mic_sd (mic_sd),
        .ledr (ledr), .ledg (ledg), .hex0 (hex0), .hex1 (hex1), .hex2 (hex2), .hex3 (hex3),
        .mic_sck (mic_sck), .mic_ws (mic_ws), .mic_lr (mic_lr)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;                           // 20 ns period

    // ------------------------------------------------------------------------
    // Reporting and compare tasks
    // ------------------------------------------------------------------------

    task automatic fail_run(input string msg);
        n_errors++;
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_hex(input string name, input logic [6:0] exp, input logic [6:0] act);
        if (act !== exp)
            fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_dp(input string name, input digit_sel_t exp, input digit_sel_t act);
        if (act !== exp)
            fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    endtask

    // Blink bit has its own check
    task automatic check_leds(input string name, input led_bus_t exp, input led_bus_t act);
        if ({act.ledr_low, act.ledg[6:0]} !== {exp.ledr_low, exp.ledg[6:0]})
            fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("mismatch %s expected %b actual %b", name, exp, act));
    endtask

    // Active low gfedcba font of the board
    function automatic logic [6:0] hex_pattern(input logic [3:0] v);
        logic [6:0] p;
        case (v)
            4'h0:    p = 7'h40;
            4'h1:    p = 7'h79;
            4'h2:    p = 7'h24;
            4'h3:    p = 7'h30;
            4'h4:    p = 7'h19;
            4'h5:    p = 7'h12;
            4'h6:    p = 7'h02;
            4'h7:    p = 7'h78;
            4'h8:    p = 7'h00;
            4'h9:    p = 7'h10;
            4'ha:    p = 7'h08;
            4'hb:    p = 7'h03;
            4'hc:    p = 7'h46;
            4'hd:    p = 7'h21;
            4'he:    p = 7'h06;
            default: p = 7'h0e;
        endcase
        return p;
    endfunction

    // ------------------------------------------------------------------------
    // Mic model and interface monitor on the falling clk edge
    // ------------------------------------------------------------------------

    always @(negedge clk)
    begin
        if (rst)
        begin
            slot_per  = 0;                           // Left slot starts at reset
            frame_smp = mic_sample;
        end
        else if (sck_prev && !mic_sck)               // sck just fell
        begin
            if (mic_ws != ws_prev)
                slot_per = 0;
            else
                slot_per++;
            if (ws_prev && !mic_ws)
                frame_smp = mic_sample;              // New left slot
            if (mic_ws)
                mic_sd = $urandom % 2;               // Idle right slot noise
            else if (slot_per >= 1 && slot_per <= `MIC_SAMPLE_BITS)
                mic_sd = frame_smp[`MIC_SAMPLE_BITS - slot_per];   // MSB first
            else
                mic_sd = 1'b0;
        end
        sck_prev = mic_sck;
        ws_prev  = mic_ws;
    end

    always @(negedge clk)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
            fail_run("timeout, the run went past its cycle limit");
        if (!rst && mic_ws !== ws_mon && mic_sck)
            fail_run("mic_ws changed while mic_sck was high");
        if (mic_lr !== 1'b0)
            fail_run("mic_lr left the left channel setting");
        if (rst)
            sck_run = -1;                            // Timing starts at the first sck edge
        else if (mic_sck !== sck_mon)
        begin
            if (sck_run >= 0 && sck_run + 1 != `MIC_SCK_DIV)
                fail_run($sformatf("mic_sck half period was %0d clk cycles instead of %0d",
                                   sck_run + 1, `MIC_SCK_DIV));
            sck_run = 0;
        end
        else if (sck_run >= 0)
            sck_run++;
        ws_mon  = mic_ws;
        sck_mon = mic_sck;
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    task automatic read_stim();
        int          fd;
        string       line;
        string       nm;
        logic [9:0]  sw_v;
        int          np;
        logic [23:0] smp;
        logic [3:0]  dpm;
        fd = $fopen("test/tb_stim.txt", "r");
        if (fd == 0)
            fail_run("could not open the stimulus file test/tb_stim.txt");
        while ($fgets(line, fd) != 0)
            if ($sscanf(line, "%s %h %d %h %h", nm, sw_v, np, smp, dpm) == 5)
            begin
                t_name[n_tests]    = nm;
                t_sw[n_tests]      = sw_v;
                t_presses[n_tests] = np;
                t_sample[n_tests]  = smp;
                t_dp[n_tests]      = dpm;
                n_tests++;
            end                                      // Comment lines fall through
        $fclose(fd);
    endtask

    task automatic press_key(input int idx);
        key[idx] = 1'b0;                             // Pin is active low
        repeat (6) @(negedge clk);
        key[idx] = 1'b1;
        repeat (6) @(negedge clk);
    endtask

    task automatic check_blink();
        logic prev;
        int   toggles;
        toggles = 0;
        prev    = ledg[7];
        repeat (40)
        begin
            @(negedge clk);
            if (ledg[7] !== prev)
                toggles++;
            prev = ledg[7];
        end
        check_bit("blink toggles twice", 1'b1, toggles >= 2);
    endtask

    task automatic run_test(input int idx);
        logic [15:0] show;                           // Expected display word
        led_bus_t    exp_leds;
        led_bus_t    act_leds;
        sw         = t_sw[idx];
        mic_sample = t_sample[idx];
        press_key(1);                                // Clear counter
        repeat (t_presses[idx])
            press_key(0);
        if (t_sw[idx][0])
            repeat (2 * frame_cycles) @(negedge clk);   // Two full mic frames
        repeat (4 * scan_div + 2) @(negedge clk);    // Scan to latch bound
        show = t_sw[idx][0] ? t_sample[idx][23:8] : 16'(t_presses[idx]);
        check_hex($sformatf("%s hex0", t_name[idx]), hex_pattern(show[3:0]), hex0);
        check_hex($sformatf("%s hex1", t_name[idx]), hex_pattern(show[7:4]), hex1);
        check_hex($sformatf("%s hex2", t_name[idx]), hex_pattern(show[11:8]), hex2);
        check_hex($sformatf("%s hex3", t_name[idx]), hex_pattern(show[15:12]), hex3);
        check_dp($sformatf("%s dp", t_name[idx]), t_dp[idx],
                 ledr[`BOARD_W_LEDR-1 -: `BOARD_W_DIGIT]);
        exp_leds.ledr_low = t_sw[idx][5:0];
        exp_leds.ledg     = {1'b0, 7'(t_presses[idx])};
        act_leds.ledr_low = ledr[5:0];
        act_leds.ledg     = ledg;
        check_leds($sformatf("%s leds", t_name[idx]), exp_leds, act_leds);
    endtask

    initial
    begin
        int seed_val;
        rst         = 1'b1;
        key         = '1;                            // Released
        sw          = '0;
        mic_sd      = 1'b0;
        mic_sample  = '0;
        n_tests     = 0;
        n_errors    = 0;
        cycle_count = 0;
        cycle_limit = 1 << 30;
        seed_val    = $urandom(50);
        read_stim();
        cycle_limit = n_tests * 2 * frame_cycles + 2000;
        repeat (7) @(negedge clk);
        check_hex("reset hex0", 7'h7f, hex0);        // Blank while in reset
        check_hex("reset hex1", 7'h7f, hex1);
        check_hex("reset hex2", 7'h7f, hex2);
        check_hex("reset hex3", 7'h7f, hex3);
        check_dp("reset dp", '0, ledr[`BOARD_W_LEDR-1 -: `BOARD_W_DIGIT]);
        check_leds("reset leds", '0, {ledr[5:0], ledg});
        check_bit("reset blink", 1'b0, ledg[7]);
        @(negedge clk);
        rst = 1'b0;
        check_blink();
        for (int i = 0; i < n_tests; i++)
            run_test(i);
        if (n_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: test/tb_stim.txt
# name sw(hex, 10 bits) key0_presses(dec) mic_sample(hex, 24 bits) dp_mask(hex, sw[4:1])
# sw bit 0 set shows mic bits 23..8, clear shows the press count
cnt_zero   000  0 000000 0
cnt_one    000  1 000000 0
cnt_five   004  5 000000 2
cnt_nine   008  9 000000 4
cnt_ten    010 10 000000 8
cnt_15     01e 15 000000 f
cnt_16     020 16 000000 0
cnt_17     200 17 000000 0
cnt_20     03e 20 000000 f
cnt_three  100  3 000000 0
cnt_12     006 12 000000 3
cnt_seven  00a  7 000000 5
cnt_two    3c0  2 000000 0
cnt_19     02a 19 000000 5
mic_pos    001  0 123456 0
mic_neg    001  1 fedcba 0
mic_max    003  0 7fffff 1
mic_min    021  2 800000 0
mic_a5     005  0 a5a5a5 2
mic_5a     009  3 5a5a5a 4
mic_beef   011  0 beef01 8
mic_dead   01f  1 dead99 f
mic_zero   201  0 000000 0
mic_c0de   03f  2 c0de77 f
mic_9876   101  0 987654 0
mic_ones   001  0 ffffff 0
